// File: common/bram_fifo_pkg.sv
/*
 * Shared definitions of the block-RAM readout FIFO:
 * bus widths, core version, data word type, register map
 * and the request and status structs.
 */
package bram_fifo_pkg;

    localparam int BUS_ADDR_W = 16;          // register bus address width
    localparam logic [7:0] VERSION = 8'd2;   // read back at address 0

    typedef logic [31:0] fifo_word_t;

    // register map of the 8-bit register file
    typedef enum logic [BUS_ADDR_W-1:0] {
        ADDR_RST_VERSION  = 16'd0,  // write: soft reset, read: version
        ADDR_ALMOST_FULL  = 16'd1,
        ADDR_ALMOST_EMPTY = 16'd2,
        ADDR_READ_ERRORS  = 16'd3,
        ADDR_SIZE_B0      = 16'd4,  // live size, also takes the snapshot
        ADDR_SIZE_B1      = 16'd5,
        ADDR_SIZE_B2      = 16'd6,
        ADDR_SIZE_B3      = 16'd7
    } reg_addr_e;

    typedef struct packed {
        logic [BUS_ADDR_W-1:0] add;
        logic [7:0]            wdata;
        logic                  rd;
        logic                  wr;
    } reg_req_t;

    typedef struct packed {
        logic       rd;
        logic       wr;
        fifo_word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic not_empty;
        logic full;
        logic near_full;
        logic read_error;
    } fifo_status_t;

endpackage

// File: bram_fifo/generic_fifo.sv
/*
 * First-word-fall-through FIFO on an inferred dual-port RAM.
 * Keeps read and write pointers and an occupancy count.
 */
module generic_fifo #(
    parameter int DEPTH = 64
) (
    input  logic                       BUS_CLK,
    input  logic                       rst,
    input  logic                       push,
    input  bram_fifo_pkg::fifo_word_t  push_data,
    input  logic                       pop,
    output bram_fifo_pkg::fifo_word_t  pop_data,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(DEPTH):0]     occupancy
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;   // holds 0 up to DEPTH
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    bram_fifo_pkg::fifo_word_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // drop on full
    assign do_pop  = pop && !empty;   // ignore on empty

    always_ff @(posedge BUS_CLK)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps, DEPTH is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none or both
            endcase
        end
    end

    assign pop_data  = mem[rd_ptr];   // head word, fall-through
    assign full      = (count == FULL_CNT);
    assign empty     = (count == '0);
    assign occupancy = count;

endmodule

// File: bram_fifo/fifo_level_monitor.sv
/*
 * Near-full flag with set/clear hysteresis.
 * Thresholds scale the 8-bit register values to DEPTH.
 */
module fifo_level_monitor #(
    parameter int DEPTH = 64
) (
    input  logic                   BUS_CLK,
    input  logic                   rst,
    input  logic [$clog2(DEPTH):0] occupancy,
    input  logic [7:0]             almost_full,
    input  logic [7:0]             almost_empty,
    output logic                   near_full
);

    logic [31:0] occ_ext;
    logic [31:0] set_thr;
    logic [31:0] clr_thr;
    logic        set_cond;
    logic        clr_cond;

    assign occ_ext = 32'(occupancy);

    // (value + 1) * DEPTH / 256, rounded down
    assign set_thr = ((32'(almost_full) + 32'd1) * 32'(DEPTH)) >> 8;
    assign clr_thr = ((32'(almost_empty) + 32'd1) * 32'(DEPTH)) >> 8;

    assign set_cond = (occ_ext >= set_thr) || (almost_full == 8'd0);
    assign clr_cond = ((almost_empty != 8'd0) && (occ_ext <= clr_thr))
                      || (occ_ext == 32'd0);

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            near_full <= 1'b0;
        end
        else if (set_cond)
        begin
            near_full <= 1'b1;   // set wins over clear
        end
        else if (clr_cond)
        begin
            near_full <= 1'b0;
        end
    end

endmodule

// File: bram_fifo/bram_fifo_core.sv
/*
 * Readout FIFO core: register file with soft reset, size snapshot,
 * saturating read-error counter, host data port, push-source mux
 * and status flags around the RAM FIFO and the level monitor.
 */
module bram_fifo_core #(
    parameter int DEPTH = 64
) (
    input  logic                          BUS_CLK,
    input  logic                          RST,
    input  bram_fifo_pkg::reg_req_t       reg_req,
    output logic [7:0]                    reg_rdata,
    input  bram_fifo_pkg::data_req_t      data_req,
    output bram_fifo_pkg::fifo_word_t     data_rdata,
    input  logic                          src_empty,
    input  bram_fifo_pkg::fifo_word_t     src_data,
    output logic                          src_read_next,
    output bram_fifo_pkg::fifo_status_t   status
);

    localparam int CNT_W = $clog2(DEPTH) + 1;
    localparam logic [7:0] AF_DEFAULT = 8'(255 * 95 / 100);   // 242
    localparam logic [7:0] AE_DEFAULT = 8'(255 * 5 / 100);    // 12

    logic                      soft_rst;
    logic                      rst;
    logic [7:0]                status_regs [8];
    logic [7:0]                read_err_cnt;
    logic [31:0]               size_bytes;
    logic [31:0]               size_snap;
    logic                      push;
    bram_fifo_pkg::fifo_word_t push_data;
    logic                      pop;
    bram_fifo_pkg::fifo_word_t pop_data;
    logic                      full;
    logic                      empty;
    logic [CNT_W-1:0]          occupancy;
    logic                      near_full;

    assign soft_rst = reg_req.wr && (reg_req.add == bram_fifo_pkg::ADDR_RST_VERSION);
    assign rst      = RST || soft_rst;

    // register file, 1 and 2 drive the monitor
    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
                status_regs[i] <= 8'd0;
            status_regs[1] <= AF_DEFAULT;
            status_regs[2] <= AE_DEFAULT;
        end
        else if (reg_req.wr && (reg_req.add < 16'd8))
        begin
            status_regs[reg_req.add[2:0]] <= reg_req.wdata;
        end
    end

    assign size_bytes = {{(32 - CNT_W - 2){1'b0}}, occupancy, 2'b00};   // words x 4

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            size_snap <= '0;
        else if (reg_req.rd && (reg_req.add == bram_fifo_pkg::ADDR_SIZE_B0))
            size_snap <= size_bytes;   // upper bytes read from here
    end

    // registered read mux, follows the address every cycle
    always_ff @(posedge BUS_CLK)
    begin
        case (reg_req.add)
            bram_fifo_pkg::ADDR_RST_VERSION:  reg_rdata <= bram_fifo_pkg::VERSION;
            bram_fifo_pkg::ADDR_ALMOST_FULL:  reg_rdata <= status_regs[1];
            bram_fifo_pkg::ADDR_ALMOST_EMPTY: reg_rdata <= status_regs[2];
            bram_fifo_pkg::ADDR_READ_ERRORS:  reg_rdata <= read_err_cnt;
            bram_fifo_pkg::ADDR_SIZE_B0:      reg_rdata <= size_bytes[7:0];
            bram_fifo_pkg::ADDR_SIZE_B1:      reg_rdata <= size_snap[15:8];
            bram_fifo_pkg::ADDR_SIZE_B2:      reg_rdata <= size_snap[23:16];
            bram_fifo_pkg::ADDR_SIZE_B3:      reg_rdata <= size_snap[31:24];
            default:                          reg_rdata <= 8'd0;
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            read_err_cnt <= 8'd0;
        else if (data_req.rd && empty && (read_err_cnt != 8'hff))
            read_err_cnt <= read_err_cnt + 8'd1;   // saturates at 255
    end

    // host write beats the upstream word
    assign push      = data_req.wr || !src_empty;
    assign push_data = data_req.wr ? data_req.wdata : src_data;
    assign pop       = data_req.rd && !empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (pop)
            data_rdata <= pop_data;   // holds until the next pop
    end

    generic_fifo #(
        .DEPTH(DEPTH)
    ) i_buf_fifo (
        .BUS_CLK  (BUS_CLK),
        .rst      (rst),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .pop_data (pop_data),
        .full     (full),
        .empty    (empty),
        .occupancy(occupancy)
    );

    fifo_level_monitor #(
        .DEPTH(DEPTH)
    ) i_level_mon (
        .BUS_CLK     (BUS_CLK),
        .rst         (rst),
        .occupancy   (occupancy),
        .almost_full (status_regs[1]),
        .almost_empty(status_regs[2]),
        .near_full   (near_full)
    );

    assign src_read_next     = !full;
    assign status.not_empty  = !empty;
    assign status.full       = full;
    assign status.near_full  = near_full;
    assign status.read_error = (read_err_cnt != 8'd0);

endmodule

// File: source/bram_fifo_top.sv
/*
 * Top level of the block-RAM readout FIFO.
 * Sets the buffer depth and connects the core to the outside.
 */
module bram_fifo_top #(
    parameter int DEPTH = 64   // words, power of two
) (
    input  logic                          BUS_CLK,
    input  logic                          RST,
    input  bram_fifo_pkg::reg_req_t       reg_req,
    output logic [7:0]                    reg_rdata,
    input  bram_fifo_pkg::data_req_t      data_req,
    output bram_fifo_pkg::fifo_word_t     data_rdata,
    input  logic                          src_empty,
    input  bram_fifo_pkg::fifo_word_t     src_data,
    output logic                          src_read_next,
    output bram_fifo_pkg::fifo_status_t   status
);

    bram_fifo_core #(
        .DEPTH(DEPTH)
    ) i_core (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .reg_req      (reg_req),
        .reg_rdata    (reg_rdata),
        .data_req     (data_req),
        .data_rdata   (data_rdata),
        .src_empty    (src_empty),
        .src_data     (src_data),
        .src_read_next(src_read_next),
        .status       (status)
    );

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset: period 8, reset for 3 cycles.
 */
module tb_clock_gen (
    output logic BUS_CLK,
    output logic RST
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        BUS_CLK = 1'b0;
        forever #HALF_PERIOD BUS_CLK = ~BUS_CLK;
    end

    initial
    begin
        RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge BUS_CLK);
        RST <= 1'b0;   // released after the third edge
    end

endmodule

// File: verif/tb_bram_fifo.sv
/*
 * Readout FIFO testbench with LFSR stimulus, a queue model of the
 * buffer and registers, compare tasks, watchdog and summary.
 */
module tb_bram_fifo;

    localparam int DEPTH       = 64;
    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 4 + 164 + 160 + 301 + 6 * 142 + 54;   // per-test cycle bounds
    localparam logic [7:0] AF_RESET = 8'd242;   // 95% of 255
    localparam logic [7:0] AE_RESET = 8'd12;    // 5% of 255

    logic                        BUS_CLK;
    logic                        RST;
    bram_fifo_pkg::reg_req_t     reg_req;
    logic [7:0]                  reg_rdata;
    bram_fifo_pkg::data_req_t    data_req;
    bram_fifo_pkg::fifo_word_t   data_rdata;
    logic                        src_empty;
    bram_fifo_pkg::fifo_word_t   src_data;
    logic                        src_read_next;
    bram_fifo_pkg::fifo_status_t status;

    logic [31:0]               lfsr = 32'h532d;
    bram_fifo_pkg::fifo_word_t model_q [$];
    bram_fifo_pkg::fifo_word_t last_word;
    logic                      word_valid = 1'b0;   // data_rdata unknown before first pop
    logic [7:0]                af;
    logic [7:0]                ae;
    logic [7:0]                err_cnt;
    logic [31:0]               snap;
    logic                      nf;
    int                        errors = 0;
    int                        tests = 0;
    int                        failed = 0;
    int                        test_start;

    tb_clock_gen i_clk_gen (
        .BUS_CLK(BUS_CLK),
        .RST    (RST)
    );

    bram_fifo_top #(
        .DEPTH(DEPTH)
    ) UUT (.*);

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 32'h8020_0003;   // taps 32 22 2 1
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic int threshold(logic [7:0] v);
        return ((int'(v) + 1) * DEPTH) / 256;
    endfunction

    function automatic logic [7:0] expect_reg(logic [15:0] add, int occ);
        logic [31:0] size;
        size = occ * 4;   // bytes
        case (add)
            16'd0:   return bram_fifo_pkg::VERSION;
            16'd1:   return af;
            16'd2:   return ae;
            16'd3:   return err_cnt;
            16'd4:   return size[7:0];
            16'd5:   return snap[15:8];
            16'd6:   return snap[23:16];
            16'd7:   return snap[31:24];
            default: return 8'd0;
        endcase
    endfunction

    task automatic compare_word(string name, bram_fifo_pkg::fifo_word_t got,
                                bram_fifo_pkg::fifo_word_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_reg(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flags(string name, bram_fifo_pkg::fifo_status_t got,
                                 bram_fifo_pkg::fifo_status_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic model_reset();
        model_q.delete();
        af      = AF_RESET;
        ae      = AE_RESET;
        err_cnt = 8'd0;
        snap    = '0;
        nf      = 1'b0;
    endtask

    // drive at the falling edge and check at the next one
    task automatic step(bram_fifo_pkg::reg_req_t r, bram_fifo_pkg::data_req_t d,
                        logic se, bram_fifo_pkg::fifo_word_t sd);
        int                          occ;
        logic [7:0]                  exp_rdata;
        bram_fifo_pkg::fifo_status_t exp_st;
        reg_req   = r;
        data_req  = d;
        src_empty = se;
        src_data  = sd;
        occ       = model_q.size();
        exp_rdata = expect_reg(r.add, occ);
        if (r.wr && r.add == 16'd0)
            model_reset();
        else
        begin
            if (occ >= threshold(af) || af == 8'd0)
                nf = 1'b1;
            else if ((ae != 8'd0 && occ <= threshold(ae)) || occ == 0)
                nf = 1'b0;
            if (r.wr && r.add == 16'd1)
                af = r.wdata;
            if (r.wr && r.add == 16'd2)
                ae = r.wdata;
            if (r.rd && r.add == 16'd4)
                snap = occ * 4;
            if (d.rd && occ == 0 && err_cnt != 8'hff)
                err_cnt++;
            if (d.rd && occ != 0)
            begin
                last_word  = model_q.pop_front();
                word_valid = 1'b1;
            end
            if ((d.wr || !se) && occ < DEPTH)
                model_q.push_back(d.wr ? d.wdata : sd);   // host word wins
        end
        @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        compare_reg("reg_rdata", reg_rdata, exp_rdata);
        if (word_valid)
            compare_word("data_rdata", data_rdata, last_word);
        exp_st.not_empty  = model_q.size() != 0;
        exp_st.full       = model_q.size() == DEPTH;
        exp_st.near_full  = nf;
        exp_st.read_error = err_cnt != 8'd0;
        compare_flags("status", status, exp_st);
        compare_bit("src_read_next", src_read_next, model_q.size() != DEPTH);
    endtask

    task automatic reg_access(logic [15:0] add, logic wr, logic [7:0] wdata, logic se);
        bram_fifo_pkg::reg_req_t r;
        r.add   = add;
        r.wdata = wdata;
        r.rd    = !wr;
        r.wr    = wr;
        step(r, '0, se, rand_bits(32));
    endtask

    task automatic data_cycle(logic rd, logic wr, logic se);
        bram_fifo_pkg::data_req_t d;
        d.rd    = rd;
        d.wr    = wr;
        d.wdata = rand_bits(32);
        step('0, d, se, rand_bits(32));
    endtask

    task automatic drain();
        while (model_q.size() > 0)
            data_cycle(1'b1, 1'b0, 1'b1);
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors == test_start)
            $display("test %s: ok", name);
        else
        begin
            failed++;
            $display("test %s: %0d mismatches", name, errors - test_start);
        end
    endtask

    task automatic test_reset_values();
        test_start = errors;
        for (int a = 0; a < 4; a++)
            reg_access(16'(a), 1'b0, 8'd0, 1'b1);
        end_test("reset values");
    endtask

    task automatic test_push_pop();
        test_start = errors;
        repeat (100) data_cycle(1'b0, 1'b0, rand_bits(2) == 0);   // about 75% pushes
        drain();
        end_test("upstream push and read");
    endtask

    task automatic test_size_regs();
        int n;
        test_start = errors;
        n = 8 + rand_bits(4);
        repeat (n) data_cycle(1'b0, 1'b0, 1'b0);
        reg_access(16'd4, 1'b0, 8'd0, 1'b1);
        for (int a = 5; a < 8; a++)
            reg_access(16'(a), 1'b0, 8'd0, 1'b0);   // pushes go on
        while (model_q.size() < DEPTH)
            data_cycle(1'b0, 1'b0, 1'b0);
        reg_access(16'd4, 1'b0, 8'd0, 1'b1);        // 256 bytes
        repeat (4) data_cycle(1'b1, 1'b0, 1'b1);
        for (int a = 5; a < 8; a++)
            reg_access(16'(a), 1'b0, 8'd0, 1'b0);
        drain();
        end_test("size registers");
    endtask

    task automatic test_empty_reads();
        test_start = errors;
        drain();
        repeat (300) data_cycle(1'b1, 1'b0, 1'b1);
        reg_access(16'd3, 1'b0, 8'd0, 1'b1);
        compare_reg("read_errors", reg_rdata, 8'hff);
        compare_bit("read_error", status.read_error, 1'b1);
        end_test("empty reads");
    endtask

    task automatic test_near_full();
        test_start = errors;
        for (int k = 0; k < 6; k++)
        begin
            reg_access(16'd1, 1'b1, (k == 0) ? 8'd0 : 8'(rand_bits(8)), 1'b1);
            reg_access(16'd2, 1'b1, (k == 1) ? 8'd0 : 8'(rand_bits(8)), 1'b1);
            repeat (70) data_cycle(rand_bits(2) == 0, 1'b0, rand_bits(2) == 0);  // filling
            repeat (70) data_cycle(rand_bits(2) != 0, 1'b0, rand_bits(2) != 0);  // draining
        end
        end_test("near-full hysteresis");
    endtask

    task automatic test_host_write();
        test_start = errors;
        repeat (20) data_cycle(rand_bits(1) != 0, 1'b1, 1'b0);   // upstream word lost
        drain();
        reg_access(16'd1, 1'b1, 8'h40, 1'b1);
        reg_access(16'd2, 1'b1, 8'h05, 1'b1);
        repeat (3) data_cycle(1'b1, 1'b0, 1'b1);
        repeat (5) data_cycle(1'b0, 1'b1, 1'b1);
        reg_access(16'd0, 1'b1, 8'(rand_bits(8)), 1'b1);     // soft reset
        for (int a = 1; a < 4; a++)
            reg_access(16'(a), 1'b0, 8'd0, 1'b1);
        end_test("host write and soft reset");
    endtask

    initial
    begin
        reg_req   = '0;
        data_req  = '0;
        src_empty = 1'b1;
        src_data  = '0;
        model_reset();
        wait (RST === 1'b0);
        @(negedge BUS_CLK);
        test_reset_values();
        test_push_pop();
        test_size_regs();
        test_empty_reads();
        test_near_full();
        test_host_write();
        $display("tests run %0d, tests failed %0d, mismatches %0d", tests, failed, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired before all tests completed");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: bram_fifo.f
common/bram_fifo_pkg.sv
bram_fifo/generic_fifo.sv
bram_fifo/fifo_level_monitor.sv
bram_fifo/bram_fifo_core.sv
source/bram_fifo_top.sv
verif/tb_clock_gen.sv
verif/tb_bram_fifo.sv

// File: Bender.yml
package:
  name: bram_fifo

sources:
  - common/bram_fifo_pkg.sv
  - bram_fifo/generic_fifo.sv
  - bram_fifo/fifo_level_monitor.sv
  - bram_fifo/bram_fifo_core.sv
  - source/bram_fifo_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_bram_fifo.sv
